/* sim.f */
+incdir+include
hw/cheat_pkg.sv
hw/cheat_code_loader.sv
hw/cheat_slot.sv
hw/cheat_patch_merge.sv
hw/cheat_engine_top.sv
testbench/cheat_checker.sv
testbench/tb_cheat_engine.sv

/* Bender.yml */
package:
  name: cheat_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/cheat_pkg.sv
      - hw/cheat_code_loader.sv
      - hw/cheat_slot.sv
      - hw/cheat_patch_merge.sv
      - hw/cheat_engine_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/cheat_checker.sv
      - testbench/tb_cheat_engine.sv

/* testbench/tb_cheat_engine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cheat_config.svh"

module tb_cheat_engine;

	localparam int STIM_CYCLES    = 5000;  // All phases with back-pressure rounded up
	localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;
	localparam logic [`ROM_ADDR_W-1:0] WINDOW_BASE = 22'h000100;  // Small window so hits are frequent

	logic                  clk_sys = 1'b0;
	logic                  rst_n;
	logic                  clear;
	logic                  cheats_en;
	logic                  code_valid;
	cheat_pkg::code_byte_t code_byte;
	logic                  rd_req_valid;
	cheat_pkg::rd_req_t    rd_req;
	logic                  rd_rsp_ready;
	wire                   codes_full;
	wire                   rd_req_ready;
	wire                   rd_rsp_valid;
	wire cheat_pkg::rd_rsp_t rd_rsp;
	logic                  bp_en;
	int                    cycle_count = 0;
	int                    error_count;
	int                    pending;

	always #5 clk_sys = ~clk_sys;

	cheat_engine_top UUT (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.clear        (clear),
		.cheats_en    (cheats_en),
		.code_valid   (code_valid),
		.code_byte    (code_byte),
		.rd_req_valid (rd_req_valid),
		.rd_req       (rd_req),
		.rd_rsp_ready (rd_rsp_ready),
		.codes_full   (codes_full),
		.rd_req_ready (rd_req_ready),
		.rd_rsp_valid (rd_rsp_valid),
		.rd_rsp       (rd_rsp)
	);

	cheat_checker u_checker (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.clear        (clear),
		.cheats_en    (cheats_en),
		.code_valid   (code_valid),
		.code_byte    (code_byte),
		.rd_req_valid (rd_req_valid),
		.rd_req_ready (rd_req_ready),
		.rd_req       (rd_req),
		.rd_rsp_valid (rd_rsp_valid),
		.rd_rsp_ready (rd_rsp_ready),
		.rd_rsp       (rd_rsp),
		.codes_full   (codes_full),
		.error_count  (error_count),
		.pending      (pending)
	);

	// ====================
	// Back-pressure and timeout
	// ====================
	always @(posedge clk_sys) begin
		if (bp_en) begin
			rd_rsp_ready <= 1'($urandom_range(0, 1));
		end else begin
			rd_rsp_ready <= 1'b1;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ====================
	// Stimulus tasks
	// ====================

	// Sends one 16-byte record, LSB first per field; unused bits are random
	task automatic load_code(input logic cmp_en, input logic [`ROM_ADDR_W-1:0] addr,
			input logic [`ROM_DATA_W-1:0] cmp, input logic [`ROM_DATA_W-1:0] repl);
		logic [`CODE_FIELD_W-1:0] fields [4];
		int                       i;
		fields[0]       = $urandom();
		fields[0][0]    = cmp_en;
		fields[1]       = $urandom();
		fields[1][21:0] = addr;
		fields[2]       = $urandom();
		fields[2][7:0]  = cmp;
		fields[3]       = $urandom();
		fields[3][7:0]  = repl;
		for (i = 0; i < `CODE_BYTES; i++) begin
			code_valid     <= 1'b1;
			code_byte.pos  <= i[3:0];
			code_byte.data <= fields[i / 4][(i % 4) * 8 +: 8];
			@(posedge clk_sys);
		end
		code_valid <= 1'b0;
		repeat (3) @(posedge clk_sys);  // Let the slot write land
	endtask

	task automatic clear_table();
		clear <= 1'b1;
		@(posedge clk_sys);
		clear <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic run_reads(input int count, input logic gaps);
		logic [`ROM_ADDR_W-1:0] addr;
		logic [`ROM_DATA_W-1:0] raw;
		int                     n;
		for (n = 0; n < count; n++) begin
			if (gaps && $urandom_range(0, 3) == 0) begin
				rd_req_valid <= 1'b0;  // Idle cycle
				@(posedge clk_sys);
			end
			addr = WINDOW_BASE + `ROM_ADDR_W'($urandom_range(0, 15));
			if ($urandom_range(0, 3) == 0) begin
				raw = 8'($urandom());
			end else begin
				raw = 8'hA0 + 8'($urandom_range(0, 3));  // Near the compare values
			end
			rd_req_valid <= 1'b1;
			rd_req.addr  <= addr;
			rd_req.data  <= raw;
			@(posedge clk_sys);
			while (!rd_req_ready) @(posedge clk_sys);  // Hold until accepted
		end
		rd_req_valid <= 1'b0;
	endtask

	// Waits until every accepted request has been answered
	task automatic drain();
		do @(negedge clk_sys); while (pending != 0);
		repeat (2) @(posedge clk_sys);
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		rst_n        = 1'b0;
		clear        = 1'b0;
		cheats_en    = 1'b1;
		code_valid   = 1'b0;
		code_byte    = '0;
		rd_req_valid = 1'b0;
		rd_req       = '0;
		rd_rsp_ready = 1'b1;
		bp_en        = 1'b0;
		void'($urandom(32'hd25e));
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_sys);

		run_reads(200, 1'b0);  // Empty table
		drain();
		load_code(1'b0, WINDOW_BASE + 22'h4, 8'h00, 8'h5A);  // Unconditional
		run_reads(200, 1'b0);
		drain();
		load_code(1'b1, WINDOW_BASE + 22'h8, 8'hA2, 8'hC3);  // Compare
		run_reads(200, 1'b0);
		drain();

		cheats_en <= 1'b0;  // Global bypass
		run_reads(100, 1'b0);
		drain();
		cheats_en <= 1'b1;
		load_code(1'b0, WINDOW_BASE + 22'h4, 8'h00, 8'h77);  // Loses to slot 0
		load_code(1'b0, WINDOW_BASE + 22'h8, 8'h00, 8'h99);  // Behind the compare code
		run_reads(200, 1'b0);
		drain();

		load_code(1'b0, WINDOW_BASE + 22'hC, 8'h00, 8'hEE);  // Table full, dropped
		run_reads(200, 1'b0);
		drain();
		clear_table();
		run_reads(100, 1'b0);
		drain();

		load_code(1'b1, WINDOW_BASE + 22'h1, 8'hA1, 8'h3C);
		load_code(1'b0, WINDOW_BASE + 22'hF, 8'h00, 8'hF0);
		bp_en <= 1'b1;
		run_reads(1000, 1'b1);
		drain();
		bp_en <= 1'b0;
		@(negedge clk_sys);

		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/cheat_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cheat_config.svh"

module cheat_checker (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        clear,
	input  wire                        cheats_en,
	input  wire                        code_valid,
	input  wire cheat_pkg::code_byte_t code_byte,
	input  wire                        rd_req_valid,
	input  wire                        rd_req_ready,
	input  wire cheat_pkg::rd_req_t    rd_req,
	input  wire                        rd_rsp_valid,
	input  wire                        rd_rsp_ready,
	input  wire cheat_pkg::rd_rsp_t    rd_rsp,
	input  wire                        codes_full,
	output int                         error_count,
	output int                         pending
);

	cheat_pkg::slot_code_t  codes [$];  // Committed codes in slot order
	cheat_pkg::rd_rsp_t     exp_q [$];  // Expected responses in request order
	logic [`ROM_DATA_W-1:0] rec [`CODE_BYTES];

	initial begin
		error_count = 0;
		pending     = 0;
	end

	// ====================
	// Reference model
	// ====================

	// First matching code in slot order wins
	function automatic cheat_pkg::rd_rsp_t expect_rsp(input cheat_pkg::rd_req_t req,
			input logic en);
		cheat_pkg::rd_rsp_t rsp;
		logic               found;
		int                 i;
		rsp.data    = req.data;
		rsp.patched = 1'b0;
		found       = 1'b0;
		for (i = 0; i < codes.size(); i++) begin
			if (!found && en && codes[i].addr == req.addr &&
					(!codes[i].cmp_en || codes[i].cmp == req.data)) begin
				found       = 1'b1;
				rsp.data    = codes[i].repl;
				rsp.patched = 1'b1;
			end
		end
		return rsp;
	endfunction

	function automatic cheat_pkg::slot_code_t record_to_code();
		cheat_pkg::slot_code_t code;
		code.valid  = 1'b1;
		code.cmp_en = rec[0][0];                    // Flags bit 0
		code.addr   = {rec[6][5:0], rec[5], rec[4]}; // Low 22 address bits
		code.cmp    = rec[8];
		code.repl   = rec[12];
		return code;
	endfunction

	// ====================
	// Comparison
	// ====================
	always @(posedge clk_sys) begin
		cheat_pkg::rd_rsp_t exp;
		logic               exp_ready;
		if (!rst_n) begin
			codes.delete();
			exp_q.delete();
		end else begin
			if (codes_full !== (codes.size() == `CHEAT_SLOTS)) begin
				$display("CHECK FAILED at %0t: codes_full expected %0b actual %0b",
					$time, codes.size() == `CHEAT_SLOTS, codes_full);
				error_count++;
			end
			// Two-deep pipe only blocks when full and not drained
			exp_ready = (exp_q.size() < 2) || rd_rsp_ready;
			if (rd_req_ready !== exp_ready) begin
				$display("CHECK FAILED at %0t: rd_req_ready expected %0b actual %0b",
					$time, exp_ready, rd_req_ready);
				error_count++;
			end
			if ($isunknown(rd_rsp_valid)) begin
				$display("Error at %0t: response valid is unknown after reset", $time);
				error_count++;
			end else if (rd_rsp_valid && rd_rsp_ready) begin
				if (exp_q.size() == 0) begin
					$display("Error at %0t: response delivered with no pending request", $time);
					error_count++;
				end else begin
					exp = exp_q.pop_front();
					if (rd_rsp.data !== exp.data) begin
						$display("CHECK FAILED at %0t: rd_rsp.data expected 0x%02h actual 0x%02h",
							$time, exp.data, rd_rsp.data);
						error_count++;
					end
					if (rd_rsp.patched !== exp.patched) begin
						$display("CHECK FAILED at %0t: rd_rsp.patched expected %0b actual %0b",
							$time, exp.patched, rd_rsp.patched);
						error_count++;
					end
				end
			end
			if (rd_req_valid && rd_req_ready) begin
				exp_q.push_back(expect_rsp(rd_req, cheats_en));
			end
			// Table update after the request sees the old contents
			if (clear) begin
				codes.delete();
			end else if (code_valid) begin
				rec[code_byte.pos] = code_byte.data;
				if (code_byte.pos == 4'(`CODE_BYTES - 1) && codes.size() < `CHEAT_SLOTS) begin
					codes.push_back(record_to_code());
				end
			end
		end
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

/* hw/cheat_engine_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cheat_config.svh"

module cheat_engine_top (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        clear,
	input  wire                        cheats_en,
	input  wire                        code_valid,
	input  wire cheat_pkg::code_byte_t code_byte,
	input  wire                        rd_req_valid,
	input  wire cheat_pkg::rd_req_t    rd_req,
	input  wire                        rd_rsp_ready,
	output wire                        codes_full,
	output wire                        rd_req_ready,
	output wire                        rd_rsp_valid,
	output wire cheat_pkg::rd_rsp_t    rd_rsp
);

	wire [`CHEAT_SLOTS-1:0]     slot_wr_en;
	wire cheat_pkg::slot_code_t slot_code;
	wire cheat_pkg::slot_hit_t  slot_hits [`CHEAT_SLOTS];
	wire                        advance;   // Shared pipeline enable

	// ====================
	// Code download
	// ====================
	cheat_code_loader u_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.clear      (clear),
		.code_valid (code_valid),
		.code_byte  (code_byte),
		.slot_wr_en (slot_wr_en),
		.slot_code  (slot_code),
		.codes_full (codes_full)
	);

	// ====================
	// Slot table
	// ====================
	for (genvar i = 0; i < `CHEAT_SLOTS; i++) begin : g_slot
		cheat_slot u_slot (
			.clk_sys (clk_sys),
			.rst_n   (rst_n),
			.clear   (clear),
			.wr_en   (slot_wr_en[i]),
			.wr_code (slot_code),
			.advance (advance),
			.req     (rd_req),
			.hit     (slot_hits[i])
		);
	end

	// ====================
	// Merge and output
	// ====================
	cheat_patch_merge u_merge (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.cheats_en    (cheats_en),
		.rd_req_valid (rd_req_valid),
		.rd_req       (rd_req),
		.hits         (slot_hits),
		.rd_rsp_ready (rd_rsp_ready),
		.advance      (advance),
		.rd_req_ready (rd_req_ready),
		.rd_rsp_valid (rd_rsp_valid),
		.rd_rsp       (rd_rsp)
	);

endmodule

`default_nettype wire

/* hw/cheat_patch_merge.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cheat_config.svh"

module cheat_patch_merge (
	input  wire                       clk_sys,
	input  wire                       rst_n,
	input  wire                       cheats_en,
	input  wire                       rd_req_valid,
	input  wire cheat_pkg::rd_req_t   rd_req,
	input  wire cheat_pkg::slot_hit_t hits [`CHEAT_SLOTS],
	input  wire                       rd_rsp_ready,
	output logic                      advance,
	output logic                      rd_req_ready,
	output logic                      rd_rsp_valid,
	output cheat_pkg::rd_rsp_t        rd_rsp
);

	logic                   s1_valid;
	logic [`ROM_DATA_W-1:0] s1_raw;   // Raw byte beside the slot hits
	logic                   out_free;
	logic                   sel_hit;
	logic [`ROM_DATA_W-1:0] sel_byte;
	logic                   patch;

	// ====================
	// Pipeline control
	// ====================
	assign out_free     = !rd_rsp_valid || rd_rsp_ready;
	assign advance      = out_free || !s1_valid; // Stage 1 free or moving on
	assign rd_req_ready = advance;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= rd_req_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (advance) begin
			s1_raw <= rd_req.data;
		end
	end

	// ====================
	// Hit priority
	// ====================

	// Walk downwards so the lowest slot is written last
	always_comb begin
		sel_hit  = 1'b0;
		sel_byte = s1_raw;
		for (int i = `CHEAT_SLOTS - 1; i >= 0; i--) begin
			if (hits[i].hit) begin
				sel_hit  = 1'b1;
				sel_byte = hits[i].repl;
			end
		end
	end

	assign patch = cheats_en && sel_hit; // Global bypass

	// ====================
	// Output register
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_rsp_valid <= 1'b0;
		end else if (out_free) begin
			rd_rsp_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (out_free && s1_valid) begin
			rd_rsp.data    <= patch ? sel_byte : s1_raw;
			rd_rsp.patched <= patch;
		end
	end

endmodule

`default_nettype wire

/* hw/cheat_slot.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cheat_config.svh"

module cheat_slot (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        clear,
	input  wire                        wr_en,
	input  wire cheat_pkg::slot_code_t wr_code,
	input  wire                        advance,
	input  wire cheat_pkg::rd_req_t    req,
	output cheat_pkg::slot_hit_t       hit
);

	logic                   code_valid;
	logic                   code_cmp_en;
	logic [`ROM_ADDR_W-1:0] code_addr;
	logic [`ROM_DATA_W-1:0] code_cmp;
	logic [`ROM_DATA_W-1:0] code_repl;
	logic                   addr_match;
	logic                   data_match;

	// ====================
	// Stored code
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n || clear) begin
			code_valid <= 1'b0;
		end else if (wr_en) begin
			code_valid <= wr_code.valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			code_cmp_en <= wr_code.cmp_en;
			code_addr   <= wr_code.addr;
			code_cmp    <= wr_code.cmp;
			code_repl   <= wr_code.repl;
		end
	end

	// ====================
	// Match
	// ====================
	assign addr_match = (req.addr == code_addr);
	assign data_match = !code_cmp_en || (req.data == code_cmp); // Compare only if enabled

	// Result follows the request into stage 1
	always_ff @(posedge clk_sys) begin
		if (advance) begin
			hit.hit  <= code_valid && addr_match && data_match;
			hit.repl <= code_repl;
		end
	end

endmodule

`default_nettype wire

/* hw/cheat_code_loader.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cheat_config.svh"

module cheat_code_loader (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire                          clear,
	input  wire                          code_valid,
	input  wire cheat_pkg::code_byte_t   code_byte,
	output logic [`CHEAT_SLOTS-1:0]      slot_wr_en,
	output cheat_pkg::slot_code_t        slot_code,
	output logic                         codes_full
);

	localparam int PTR_W = $clog2(`CHEAT_SLOTS);
	localparam int POS_W = $clog2(`CODE_BYTES);

	cheat_pkg::field_sel_e    field_sel;
	cheat_pkg::table_state_e  state;
	logic [`CODE_FIELD_W-1:0] field_q [4];
	logic [PTR_W-1:0]         wr_ptr;  // Next free slot
	logic                     last_byte;
	logic                     byte_take;

	// ====================
	// Byte capture
	// ====================

	// Top two position bits pick the field
	always_comb begin
		case (code_byte.pos[POS_W-1:POS_W-2])
			2'd0: field_sel = cheat_pkg::FIELD_FLAGS;
			2'd1: field_sel = cheat_pkg::FIELD_ADDR;
			2'd2: field_sel = cheat_pkg::FIELD_CMP;
			default: field_sel = cheat_pkg::FIELD_REPL;
		endcase
	end

	assign byte_take = code_valid && !clear; // Clear has priority
	assign last_byte = byte_take && (code_byte.pos == POS_W'(`CODE_BYTES - 1));

	always_ff @(posedge clk_sys) begin
		if (byte_take) begin
			field_q[field_sel][code_byte.pos[1:0]*`ROM_DATA_W +: `ROM_DATA_W] <= code_byte.data;
		end
	end

	// ====================
	// Slot fill
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!rst_n || clear) begin
			state      <= cheat_pkg::TABLE_EMPTY;
			wr_ptr     <= '0;
			slot_wr_en <= '0;
		end else begin
			slot_wr_en <= '0; // Single-cycle strobe
			if (last_byte && state != cheat_pkg::TABLE_FULL) begin
				slot_wr_en <= `CHEAT_SLOTS'(1) << wr_ptr;
				wr_ptr     <= wr_ptr + 1'b1;
				if (wr_ptr == PTR_W'(`CHEAT_SLOTS - 1)) begin
					state <= cheat_pkg::TABLE_FULL;
				end else begin
					state <= cheat_pkg::TABLE_FILLING;
				end
			end
		end
	end

	assign codes_full = (state == cheat_pkg::TABLE_FULL);

	// Fields still hold the finished record during the strobe cycle
	always_comb begin
		slot_code.valid  = 1'b1;
		slot_code.cmp_en = field_q[cheat_pkg::FIELD_FLAGS][0];      // Flag bit 0 only
		slot_code.addr   = field_q[cheat_pkg::FIELD_ADDR][`ROM_ADDR_W-1:0];
		slot_code.cmp    = field_q[cheat_pkg::FIELD_CMP][`ROM_DATA_W-1:0];
		slot_code.repl   = field_q[cheat_pkg::FIELD_REPL][`ROM_DATA_W-1:0];
	end

endmodule

`default_nettype wire

/* hw/cheat_pkg.sv */
`default_nettype none

`include "cheat_config.svh"

package cheat_pkg;

	// ====================
	// Read path
	// ====================
	typedef struct packed {
		logic [`ROM_ADDR_W-1:0] addr;
		logic [`ROM_DATA_W-1:0] data; // Raw ROM byte
	} rd_req_t;

	typedef struct packed {
		logic [`ROM_DATA_W-1:0] data;
		logic                   patched;
	} rd_rsp_t;

	// ====================
	// Code download
	// ====================
	typedef struct packed {
		logic [$clog2(`CODE_BYTES)-1:0] pos; // Byte index in record
		logic [`ROM_DATA_W-1:0]         data;
	} code_byte_t;

	typedef struct packed {
		logic                   valid;
		logic                   cmp_en;
		logic [`ROM_ADDR_W-1:0] addr;
		logic [`ROM_DATA_W-1:0] cmp;
		logic [`ROM_DATA_W-1:0] repl;
	} slot_code_t;

	typedef struct packed {
		logic                   hit;
		logic [`ROM_DATA_W-1:0] repl;
	} slot_hit_t;

	typedef enum logic [1:0] {FIELD_FLAGS, FIELD_ADDR, FIELD_CMP, FIELD_REPL} field_sel_e;

	typedef enum logic [1:0] {TABLE_EMPTY, TABLE_FILLING, TABLE_FULL} table_state_e;

endpackage

`default_nettype wire

/* include/cheat_config.svh */
`ifndef CHEAT_CONFIG_SVH
`define CHEAT_CONFIG_SVH

// ====================
// Code table
// ====================
`define CHEAT_SLOTS 4

// ====================
// ROM side
// ====================
`define ROM_ADDR_W 22
`define ROM_DATA_W 8

// Download record, four fields of four bytes, LSB first
`define CODE_BYTES 16
`define CODE_FIELD_W 32

`endif
